//--- source/agu_defs.svh
`ifndef AGU_DEFS_SVH
`define AGU_DEFS_SVH

// Legal physical window, limit is exclusive
`define PHYS_BASE 32'h8000_0000
`define PHYS_LIMIT 32'h8400_0000

// Single-level page table, indexed by the low vpn bits
`define PT_ENTRIES 64
`define PT_IDX_BITS 6

`endif

//--- source/aguPkg.sv
`default_nettype none

package aguPkg;

    // Load and store opcodes handled by the address units
    typedef enum logic [3:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } memOp;

    typedef enum logic [1:0] {
        excNone,
        excMisalign,
        excAccessFault,
        excPageFault
    } aguException;

    // Address unit control
    typedef enum logic {
        aguIdle,
        aguWalking
    } aguState;

    // Page walker control
    typedef enum logic [1:0] {
        walkIdle,
        walkRead,
        walkReply
    } walkState;

    typedef struct packed {
        logic valid;
        logic [19:0] ppn;
    } pteEntry;

endpackage

`default_nettype wire

//--- source/pageWalkIf.sv
`timescale 1ns/1ns
`default_nettype none

interface pageWalkIf;
    import aguPkg::*;

    // Request, held by the requester until granted
    logic req;
    logic [19:0] vpn;

    // Response side
    logic grant;
    logic rspValid;
    // Page number width is the entry without its valid bit
    logic [$bits(pteEntry) - 2:0] ppn;
    logic fault;

    modport requester (output req, vpn, input grant, rspValid, ppn, fault);
    modport server (input req, vpn, output grant, rspValid, ppn, fault);

endinterface

`default_nettype wire

//--- source/addrGenUnit.sv
`timescale 1ns/1ns
`default_nettype none
`include "agu_defs.svh"

module addrGenUnit #(
    parameter bit isStore = 1'b0
) (
    input wire clk,
    input wire rst,
    input wire vmEnable,
    input wire opValid,
    input wire aguPkg::memOp op,
    input wire [31:0] base,
    input wire [11:0] imm,
    input wire [31:0] storeData,
    output logic busy,
    output logic outValid,
    output logic [31:0] outAddr,
    output logic [1:0] outSize,
    output logic outSignExt,
    output logic [3:0] outWmask,
    output logic [31:0] outData,
    output aguPkg::aguException outExc,
    pageWalkIf.requester walk
);
    import aguPkg::*;

    aguState state;
    logic reqPending;
    logic accept;
    logic [31:0] sum;
    logic [1:0] size;
    logic [1:0] lane;
    logic [3:0] sizeMask;
    logic misalign;
    logic [31:0] physAddr;

    function automatic logic inWindow(input logic [31:0] addr);
        return addr >= `PHYS_BASE && addr < `PHYS_LIMIT;
    endfunction

    assign accept = opValid && !busy;
    assign sum = base + {{20{imm[11]}}, imm};

    always_comb begin
        case (op)
            LB, LBU, SB: size = 2'd0;
            LH, LHU, SH: size = 2'd1;
            default: size = 2'd2;
        endcase
    end

    // Lane offset aligned down to the access size
    always_comb begin
        case (size)
            2'd0: begin
                lane = sum[1:0];
                sizeMask = 4'b0001;
            end
            2'd1: begin
                lane = {sum[1], 1'b0};
                sizeMask = 4'b0011;
            end
            default: begin
                lane = 2'b00;
                sizeMask = 4'b1111;
            end
        endcase
    end

    assign misalign = (size == 2'd1 && sum[0]) || (size == 2'd2 && sum[1:0] != 2'b00);

    // outAddr holds the virtual address while walking
    assign physAddr = {walk.ppn, outAddr[11:0]};
    assign walk.vpn = outAddr[31:12];
    assign walk.req = reqPending;
    assign busy = state == aguWalking;

    always_ff @(posedge clk) begin
        outValid <= 1'b0;
        if (rst) begin
            state <= aguIdle;
            reqPending <= 1'b0;
        end else begin
            case (state)
                aguIdle: begin
                    if (accept) begin
                        // Misaligned accesses never reach the walker
                        if (vmEnable && !misalign) begin
                            state <= aguWalking;
                            reqPending <= 1'b1;
                        end else begin
                            outValid <= 1'b1;
                        end
                    end
                end
                aguWalking: begin
                    if (walk.grant) begin
                        reqPending <= 1'b0;
                    end
                    if (walk.rspValid) begin
                        state <= aguIdle;
                        outValid <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outAddr <= sum;
            outSize <= size;
            if (misalign) begin
                outExc <= excMisalign;
            end else if (!vmEnable && !inWindow(sum)) begin
                outExc <= excAccessFault;
            end else begin
                outExc <= excNone;
            end
            if (isStore) begin
                outSignExt <= 1'b0;
                outWmask <= sizeMask << lane;
                outData <= storeData << {lane, 3'b000};
            end else begin
                outSignExt <= op == LB || op == LH;
                outWmask <= 4'b0000;
                outData <= 32'd0;
            end
        end else if (state == aguWalking && walk.rspValid) begin
            // Page fault keeps the virtual address
            if (walk.fault) begin
                outExc <= excPageFault;
            end else begin
                outAddr <= physAddr;
                outExc <= inWindow(physAddr) ? excNone : excAccessFault;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/walkArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module walkArbiter (
    input wire clk,
    input wire rst,
    pageWalkIf.server loadPort,
    pageWalkIf.server storePort,
    pageWalkIf.requester walker
);

    // Set when the store unit won the last grant and so owns the walker
    logic lastWinner;
    logic ownerBusy;
    logic pickStore;

    // On a tie the unit that lost last time goes first
    assign pickStore = storePort.req && (!loadPort.req || !lastWinner);

    assign walker.req = !ownerBusy && (loadPort.req || storePort.req);
    assign walker.vpn = pickStore ? storePort.vpn : loadPort.vpn;

    assign loadPort.grant = walker.grant && !pickStore;
    assign storePort.grant = walker.grant && pickStore;

    // Response goes back to whoever holds the walker
    assign loadPort.rspValid = walker.rspValid && !lastWinner;
    assign storePort.rspValid = walker.rspValid && lastWinner;
    assign loadPort.ppn = walker.ppn;
    assign storePort.ppn = walker.ppn;
    assign loadPort.fault = walker.fault;
    assign storePort.fault = walker.fault;

    always_ff @(posedge clk) begin
        if (rst) begin
            lastWinner <= 1'b0;
            ownerBusy <= 1'b0;
        end else if (walker.grant) begin
            lastWinner <= pickStore;
            ownerBusy <= 1'b1;
        end else if (walker.rspValid) begin
            ownerBusy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/pageWalker.sv
`timescale 1ns/1ns
`default_nettype none
`include "agu_defs.svh"

module pageWalker (
    input wire clk,
    input wire rst,
    input wire ptWrEn,
    input wire [`PT_IDX_BITS-1:0] ptWrIdx,
    input wire aguPkg::pteEntry ptWrEntry,
    pageWalkIf.server port
);
    import aguPkg::*;

    pteEntry pageTable [`PT_ENTRIES];
    walkState state;
    logic [19:0] vpnReg;
    pteEntry entryReg;
    logic highBitsSet;

    assign port.grant = port.req && state == walkIdle;
    assign port.rspValid = state == walkReply;
    assign port.ppn = entryReg.ppn;
    // No superpages, so any vpn bit above the index is a miss
    assign port.fault = !entryReg.valid || highBitsSet;

    always_ff @(posedge clk) begin
        if (ptWrEn) begin
            pageTable[ptWrIdx] <= ptWrEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= walkIdle;
        end else begin
            case (state)
                walkIdle: begin
                    if (port.grant) begin
                        state <= walkRead;
                    end
                end
                walkRead: state <= walkReply;
                walkReply: state <= walkIdle;
                default: state <= walkIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (port.grant) begin
            vpnReg <= port.vpn;
        end
        if (state == walkRead) begin
            entryReg <= pageTable[vpnReg[`PT_IDX_BITS-1:0]];
            highBitsSet <= |vpnReg[19:`PT_IDX_BITS];
        end
    end

endmodule

`default_nettype wire

//--- source/memAccessTop.sv
`timescale 1ns/1ns
`default_nettype none
`include "agu_defs.svh"

module memAccessTop (
    input wire clk,
    input wire rst,
    input wire vmEnable,
    input wire ptWrEn,
    input wire [`PT_IDX_BITS-1:0] ptWrIdx,
    input wire ptWrValid,
    input wire [19:0] ptWrPpn,
    input wire ldValid,
    input wire aguPkg::memOp ldOp,
    input wire [31:0] ldBase,
    input wire [11:0] ldImm,
    output logic ldBusy,
    output logic ldOutValid,
    output logic [31:0] ldOutAddr,
    output logic [1:0] ldOutSize,
    output logic ldOutSignExt,
    output aguPkg::aguException ldOutExc,
    input wire stValid,
    input wire aguPkg::memOp stOp,
    input wire [31:0] stBase,
    input wire [11:0] stImm,
    input wire [31:0] stData,
    output logic stBusy,
    output logic stOutValid,
    output logic [31:0] stOutAddr,
    output logic [1:0] stOutSize,
    output logic stOutSignExt,
    output logic [3:0] stOutWmask,
    output logic [31:0] stOutData,
    output aguPkg::aguException stOutExc
);
    import aguPkg::*;

    pteEntry ptWrEntry;

    pageWalkIf ldWalk ();
    pageWalkIf stWalk ();
    pageWalkIf ptWalk ();

    assign ptWrEntry = '{valid: ptWrValid, ppn: ptWrPpn};

    // Load side has no lanes or write data
    addrGenUnit #(.isStore(1'b0)) loadUnit (
        .clk(clk),
        .rst(rst),
        .vmEnable(vmEnable),
        .opValid(ldValid),
        .op(ldOp),
        .base(ldBase),
        .imm(ldImm),
        .storeData(32'd0),
        .busy(ldBusy),
        .outValid(ldOutValid),
        .outAddr(ldOutAddr),
        .outSize(ldOutSize),
        .outSignExt(ldOutSignExt),
        .outWmask(),
        .outData(),
        .outExc(ldOutExc),
        .walk(ldWalk.requester)
    );

    addrGenUnit #(.isStore(1'b1)) storeUnit (
        .clk(clk),
        .rst(rst),
        .vmEnable(vmEnable),
        .opValid(stValid),
        .op(stOp),
        .base(stBase),
        .imm(stImm),
        .storeData(stData),
        .busy(stBusy),
        .outValid(stOutValid),
        .outAddr(stOutAddr),
        .outSize(stOutSize),
        .outSignExt(stOutSignExt),
        .outWmask(stOutWmask),
        .outData(stOutData),
        .outExc(stOutExc),
        .walk(stWalk.requester)
    );

    walkArbiter arbiter (
        .clk(clk),
        .rst(rst),
        .loadPort(ldWalk.server),
        .storePort(stWalk.server),
        .walker(ptWalk.requester)
    );

    pageWalker walker (
        .clk(clk),
        .rst(rst),
        .ptWrEn(ptWrEn),
        .ptWrIdx(ptWrIdx),
        .ptWrEntry(ptWrEntry),
        .port(ptWalk.server)
    );

endmodule

`default_nettype wire

//--- tb/memAccess_sva.sv
`timescale 1ns/1ns
`default_nettype none

module memAccess_sva (
    input wire clk,
    input wire rst,
    input wire ldGrant,
    input wire stGrant,
    input wire walkerGrant,
    input wire walkerRsp,
    input wire ldOutValid,
    input wire stOutValid
);

    // Only one unit owns the walker at a time
    singleGrant: assert property (@(posedge clk) disable iff (rst)
        (ldGrant || stGrant) |=> !(ldGrant || stGrant) [*2])
        else $error("walker granted again before its response returned");

    // Response lands two cycles after the grant, and only once
    oneResponse: assert property (@(posedge clk) disable iff (rst)
        walkerGrant |-> ##1 !walkerRsp ##1 walkerRsp ##1 !walkerRsp)
        else $error("grant not followed by exactly one rspValid");

    ldStrobe: assert property (@(posedge clk) disable iff (rst) ldOutValid |=> !ldOutValid)
        else $error("load outValid longer than one cycle");

    stStrobe: assert property (@(posedge clk) disable iff (rst) stOutValid |=> !stOutValid)
        else $error("store outValid longer than one cycle");

endmodule

bind memAccessTop memAccess_sva sva (
    .clk(clk),
    .rst(rst),
    .ldGrant(ldWalk.grant),
    .stGrant(stWalk.grant),
    .walkerGrant(ptWalk.grant),
    .walkerRsp(ptWalk.rspValid),
    .ldOutValid(ldOutValid),
    .stOutValid(stOutValid)
);

`default_nettype wire

//--- tb/memAccessTb.sv
`timescale 1ns/1ns
`default_nettype none
`include "agu_defs.svh"

module memAccessTb;
    import aguPkg::*;

    logic clk;
    logic rst;
    logic vmEnable;
    logic ptWrEn;
    logic [`PT_IDX_BITS-1:0] ptWrIdx;
    logic ptWrValid;
    logic [19:0] ptWrPpn;
    logic ldValid;
    memOp ldOp;
    logic [31:0] ldBase;
    logic [11:0] ldImm;
    logic ldBusy;
    logic ldOutValid;
    logic [31:0] ldOutAddr;
    logic [1:0] ldOutSize;
    logic ldOutSignExt;
    aguException ldOutExc;
    logic stValid;
    memOp stOp;
    logic [31:0] stBase;
    logic [11:0] stImm;
    logic [31:0] stData;
    logic stBusy;
    logic stOutValid;
    logic [31:0] stOutAddr;
    logic [1:0] stOutSize;
    logic stOutSignExt;
    logic [3:0] stOutWmask;
    logic [31:0] stOutData;
    aguException stOutExc;

    // Copy of the page table as written by the testbench
    logic ptValidM [`PT_ENTRIES];
    logic [19:0] ptPpnM [`PT_ENTRIES];
    logic [31:0] seed;
    int errors;
    int checks;

    memAccessTop uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic writeEntry(input int idx, input logic valid, input logic [19:0] ppn);
        ptWrEn = 1'b1;
        ptWrIdx = idx;
        ptWrValid = valid;
        ptWrPpn = ppn;
        ptValidM[idx] = valid;
        ptPpnM[idx] = ppn;
        @(negedge clk);
        ptWrEn = 1'b0;
    endtask

    // Expected unit outputs from the address, alignment and translation rules
    task automatic predict(input bit isSt, input memOp op, input logic [31:0] base,
                           input logic [11:0] imm, input logic [31:0] data,
                           output logic [31:0] addr, output aguException exc,
                           output logic [1:0] size, output logic [3:0] wmask,
                           output logic [31:0] wdata);
        logic [31:0] va;
        logic [31:0] pa;
        logic [`PT_IDX_BITS-1:0] idx;
        va = base + {{20{imm[11]}}, imm};
        idx = va[12 +: `PT_IDX_BITS];
        pa = {ptPpnM[idx], va[11:0]};
        if (op == LB || op == LBU || op == SB) begin
            size = 2'd0;
        end else if (op == LH || op == LHU || op == SH) begin
            size = 2'd1;
        end else begin
            size = 2'd2;
        end
        addr = va;
        exc = excNone;
        if ((size == 2'd1 && va[0]) || (size == 2'd2 && va[1:0] != 2'b00)) begin
            exc = excMisalign;
        end else if (!vmEnable) begin
            if (va < `PHYS_BASE || va >= `PHYS_LIMIT) begin
                exc = excAccessFault;
            end
        end else if (va[31:12+`PT_IDX_BITS] != 0 || !ptValidM[idx]) begin
            exc = excPageFault;
        end else begin
            addr = pa;
            if (pa < `PHYS_BASE || pa >= `PHYS_LIMIT) begin
                exc = excAccessFault;
            end
        end
        wmask = 4'b0000;
        wdata = 32'd0;
        if (isSt) begin
            wmask = (size == 2'd0 ? 4'b0001 : size == 2'd1 ? 4'b0011 : 4'b1111) << va[1:0];
            wdata = data << (8 * va[1:0]);
        end
    endtask

    task automatic checkSide(input bit isSt, input int cycles, input memOp op,
                             input logic [31:0] eAddr, input aguException eExc,
                             input logic [1:0] eSize, input logic [3:0] eWm,
                             input logic [31:0] eWd);
        string tag;
        tag = isSt ? "store" : "load";
        checks++;
        if ((!vmEnable || eExc == excMisalign) && cycles != 1) begin
            errors++;
            $display("ERR %0t: %s outValid after %0d cycles, expected 1", $time, tag, cycles);
        end
        checkValue({tag, " address"}, isSt ? stOutAddr : ldOutAddr, eAddr);
        checkValue({tag, " exception"}, isSt ? stOutExc : ldOutExc, eExc);
        checkValue({tag, " size"}, isSt ? stOutSize : ldOutSize, eSize);
        checkValue({tag, " sign-extend"}, isSt ? stOutSignExt : ldOutSignExt,
                   !isSt && (op == LB || op == LH));
        // Lanes of a misaligned store carry no meaning
        if (isSt && eExc != excMisalign) begin
            checkValue("store wmask", stOutWmask, eWm);
            checkValue("store data", stOutData, eWd);
        end
    endtask

    // Issue the ops currently on the unit inputs and check each result
    task automatic launch(input bit doLd, input bit doSt);
        logic [31:0] eAddr [2];
        aguException eExc [2];
        logic [1:0] eSize [2];
        logic [3:0] eWm [2];
        logic [31:0] eWd [2];
        bit pending [2];
        int cycles;
        predict(1'b0, ldOp, ldBase, ldImm, 32'd0, eAddr[0], eExc[0], eSize[0], eWm[0], eWd[0]);
        predict(1'b1, stOp, stBase, stImm, stData, eAddr[1], eExc[1], eSize[1], eWm[1], eWd[1]);
        pending[0] = doLd;
        pending[1] = doSt;
        ldValid = doLd;
        stValid = doSt;
        @(negedge clk);
        ldValid = 1'b0;
        stValid = 1'b0;
        cycles = 1;
        while ((pending[0] || pending[1]) && cycles <= 20) begin
            if (pending[0] && ldOutValid) begin
                checkSide(1'b0, cycles, ldOp, eAddr[0], eExc[0], eSize[0], eWm[0], eWd[0]);
                pending[0] = 1'b0;
            end
            if (pending[1] && stOutValid) begin
                checkSide(1'b1, cycles, stOp, eAddr[1], eExc[1], eSize[1], eWm[1], eWd[1]);
                pending[1] = 1'b0;
            end
            if (pending[0] || pending[1]) begin
                @(negedge clk);
                cycles++;
            end
        end
        if (pending[0] || pending[1]) begin
            errors++;
            $display("Timeout: an address unit never raised outValid (time %0t)", $time);
        end
        @(negedge clk);
    endtask

    task automatic fillTable();
        logic [31:0] r;
        for (int i = 0; i < `PT_ENTRIES; i++) begin
            r = nextRand();
            if (i % 8 == 7) begin
                writeEntry(i, 1'b0, r[19:0]);
            end else if (i % 16 == 5) begin
                // Maps outside the physical window
                writeEntry(i, 1'b1, 20'h90000 | i);
            end else begin
                writeEntry(i, 1'b1, 20'h80000 + {6'd0, r[13:0]});
            end
        end
    endtask

    task automatic physLoads();
        memOp ops [5];
        logic [31:0] r;
        ops = '{LB, LH, LW, LBU, LHU};
        vmEnable = 1'b0;
        for (int i = 0; i < 15; i++) begin
            r = nextRand();
            ldOp = ops[i % 5];
            ldBase = 32'h8100_0000 + {8'd0, r[23:2], 2'b00};
            ldImm = {r[31:22], 2'b00};
            launch(1'b1, 1'b0);
        end
    endtask

    task automatic windowFaults();
        vmEnable = 1'b0;
        ldOp = LH;
        ldBase = 32'h8000_1001;
        ldImm = 12'h000;
        launch(1'b1, 1'b0);
        ldOp = LW;
        ldBase = 32'h8000_1000;
        ldImm = 12'h002;
        launch(1'b1, 1'b0);
        ldOp = LHU;
        ldBase = 32'h8000_2000;
        ldImm = 12'hFFF;
        launch(1'b1, 1'b0);
        stOp = SW;
        stBase = 32'h8000_3001;
        stImm = 12'h000;
        launch(1'b0, 1'b1);
        stOp = SH;
        stBase = 32'h8000_3003;
        launch(1'b0, 1'b1);
        // Just below and just above the window
        ldOp = LW;
        ldBase = 32'h8000_0004;
        ldImm = 12'hFF8;
        launch(1'b1, 1'b0);
        ldOp = LB;
        ldBase = `PHYS_LIMIT;
        ldImm = 12'h000;
        launch(1'b1, 1'b0);
        stOp = SB;
        stBase = 32'h0000_1000;
        launch(1'b0, 1'b1);
        // Misalign is caught before any walk
        vmEnable = 1'b1;
        ldOp = LW;
        ldBase = 32'h0000_5002;
        launch(1'b1, 1'b0);
    endtask

    task automatic storeLanes();
        memOp ops [3];
        logic [31:0] r;
        ops = '{SB, SH, SW};
        vmEnable = 1'b0;
        for (int o = 0; o < 3; o++) begin
            for (int lo = 0; lo < 4; lo++) begin
                r = nextRand();
                stOp = ops[o];
                stBase = 32'h8200_0000 + {12'd0, r[19:2], 2'b00};
                stImm = lo[11:0];
                stData = nextRand();
                launch(1'b0, 1'b1);
            end
        end
    endtask

    task automatic translatedAccess();
        logic [31:0] r;
        vmEnable = 1'b1;
        writeEntry(9, 1'b1, 20'h83FFF);
        writeEntry(10, 1'b0, 20'h80010);
        writeEntry(11, 1'b1, 20'h84000);
        for (int i = 0; i < 16; i++) begin
            r = nextRand();
            ldOp = LW;
            ldBase = {14'd0, r[5:0], r[17:8], 2'b00};
            ldImm = 12'h000;
            launch(1'b1, 1'b0);
            stOp = SH;
            stBase = {14'd0, r[11:6], r[27:18], 2'b10};
            stImm = 12'h000;
            stData = r;
            launch(1'b0, 1'b1);
        end
        ldOp = LBU;
        ldBase = {14'd0, 6'd9, 12'h7F0};
        ldImm = 12'h00F;
        launch(1'b1, 1'b0);
        ldBase = {14'd0, 6'd10, 12'h100};
        launch(1'b1, 1'b0);
        // High vpn bit set on an otherwise valid index
        ldBase = {14'd1, 6'd9, 12'h100};
        launch(1'b1, 1'b0);
        stOp = SW;
        stBase = {14'd0, 6'd11, 12'h010};
        stImm = 12'h000;
        launch(1'b0, 1'b1);
    endtask

    task automatic concurrentPair();
        logic [31:0] r;
        vmEnable = 1'b1;
        for (int i = 0; i < 3; i++) begin
            r = nextRand();
            ldOp = LH;
            ldBase = {14'd0, 6'd9, 12'h800};
            ldImm = {r[31:21], 1'b0};
            stOp = SB;
            stBase = {14'd0, r[5:0], 12'h000};
            stImm = r[17:6];
            stData = nextRand();
            launch(1'b1, 1'b1);
            checks++;
            if (ldBusy || stBusy) begin
                errors++;
                $display("ERR %0t: busy still high after both units completed", $time);
            end
        end
    endtask

    task automatic ignoreWhileBusy();
        logic [31:0] eAddr;
        aguException eExc;
        logic [1:0] eSize;
        logic [3:0] eWm;
        logic [31:0] eWd;
        logic [31:0] gotAddr;
        int pulses;
        vmEnable = 1'b1;
        ldOp = LW;
        ldBase = {14'd0, 6'd9, 12'h040};
        ldImm = 12'h000;
        predict(1'b0, ldOp, ldBase, ldImm, 32'd0, eAddr, eExc, eSize, eWm, eWd);
        ldValid = 1'b1;
        @(negedge clk);
        ldValid = 1'b0;
        @(negedge clk);
        checkValue("load busy during walk", ldBusy, 1'b1);
        // Second op with another offset, raised mid-walk and dropped before the result
        ldBase = {14'd0, 6'd9, 12'h080};
        ldValid = 1'b1;
        @(negedge clk);
        ldValid = 1'b0;
        pulses = 0;
        gotAddr = 32'd0;
        for (int i = 0; i < 20; i++) begin
            if (ldOutValid) begin
                pulses++;
                gotAddr = ldOutAddr;
            end
            @(negedge clk);
        end
        checkValue("load outValid pulses", pulses, 1);
        checkValue("load address with op raised while busy", gotAddr, eAddr);
        checkValue("load busy after walk", ldBusy, 1'b0);
    endtask

    initial begin
        seed = 32'h142db662;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        vmEnable = 1'b0;
        ptWrEn = 1'b0;
        ptWrIdx = '0;
        ptWrValid = 1'b0;
        ptWrPpn = 20'd0;
        ldValid = 1'b0;
        ldOp = LB;
        ldBase = 32'd0;
        ldImm = 12'd0;
        stValid = 1'b0;
        stOp = SB;
        stBase = 32'd0;
        stImm = 12'd0;
        stData = 32'd0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        checkValue("load outValid after reset", ldOutValid, 1'b0);
        checkValue("store outValid after reset", stOutValid, 1'b0);
        checkValue("load busy after reset", ldBusy, 1'b0);
        checkValue("store busy after reset", stBusy, 1'b0);
        fillTable();
        physLoads();
        windowFaults();
        storeLanes();
        translatedAccess();
        concurrentPair();
        ignoreWhileBusy();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/aguPkg.sv
source/pageWalkIf.sv
source/addrGenUnit.sv
source/walkArbiter.sv
source/pageWalker.sv
source/memAccessTop.sv
tb/memAccess_sva.sv
tb/memAccessTb.sv

//--- Bender.yml
package:
  name: mem_access

sources:
  - include_dirs:
      - source
    files:
      - source/aguPkg.sv
      - source/pageWalkIf.sv
      - source/addrGenUnit.sv
      - source/walkArbiter.sv
      - source/pageWalker.sv
      - source/memAccessTop.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/memAccess_sva.sv
      - tb/memAccessTb.sv
